/* verilog/soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

`define SOC_ADDR_W 32
`define SOC_DATA_W 32
// one write-enable bit per byte lane
`define SOC_STRB_W 4

//////////////////////////////////////////////////////////////////////
// address map, region field is addr[31:28]
//////////////////////////////////////////////////////////////////////

`define SOC_SEL_MSB      31
`define SOC_REGION_RAM   4'h0
`define SOC_REGION_TIMER 4'h2
`define SOC_REGION_GPIO  4'h4

// peripheral sizing
`define SOC_RAM_WORDS   256
`define SOC_GPIO_PINS   8
// read data for unmapped regions
`define SOC_DECERR_DATA 32'hDEAD_BEEF

`endif

/* verilog/soc_pkg.sv */
`include "soc_config.svh"

package soc_pkg;

    // bus payload types
    typedef logic [`SOC_ADDR_W-1:0] addr_t;
    typedef logic [`SOC_DATA_W-1:0] word_t;
    typedef logic [`SOC_STRB_W-1:0] strb_t;

    // decoder target, SEL_NONE means decode error
    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_TIMER,
        SEL_GPIO,
        SEL_NONE
    } target_sel_t;

    // timer register offsets
    typedef enum logic [3:0] {
        TMR_CTRL  = 4'h0,
        TMR_COUNT = 4'h4,
        TMR_VALUE = 4'h8
    } timer_reg_e;

    // gpio register offsets
    typedef enum logic [3:0] {
        GPIO_CTRL = 4'h0,
        GPIO_DATA = 4'h4
    } gpio_reg_e;

endpackage

/* verilog/mem_bus_if.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

interface mem_bus_if;

    // request side, held until addr_ok
    logic                   req;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] wdata;
    logic [`SOC_STRB_W-1:0] wem;

    // response side
    logic                   addr_ok;
    logic                   data_ok;
    logic [`SOC_DATA_W-1:0] rdata;

    modport master (
        output req, we, addr, wdata, wem,
        input  addr_ok, data_ok, rdata
    );

    modport slave (
        input  req, we, addr, wdata, wem,
        output addr_ok, data_ok, rdata
    );

endinterface

/* verilog/bus_decoder.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module bus_decoder (
    input  logic           clk,
    input  logic           rst_n,
    // host side
    input  logic           req_i,
    input  logic           we_i,
    input  soc_pkg::addr_t addr_i,
    input  soc_pkg::word_t wdata_i,
    input  soc_pkg::strb_t wem_i,
    output logic           addr_ok_o,
    output logic           data_ok_o,
    output soc_pkg::word_t rdata_o,
    output logic           err_o,
    // targets
    mem_bus_if.master      ram_bus,
    mem_bus_if.master      timer_bus,
    mem_bus_if.master      gpio_bus
);
    import soc_pkg::*;

    target_sel_t sel;
    target_sel_t sel_q;
    logic        live_q;
    logic        owed_q;
    logic        decerr_q;
    logic        issue;

    // region field decode
    always_comb begin
        case (addr_i[`SOC_SEL_MSB -: 4])
            `SOC_REGION_RAM:   sel = SEL_RAM;
            `SOC_REGION_TIMER: sel = SEL_TIMER;
            `SOC_REGION_GPIO:  sel = SEL_GPIO;
            default:           sel = SEL_NONE;
        endcase
    end

    // no new request while a response is owed
    assign issue = req_i && live_q && !owed_q;

    // fields go everywhere, req only to the selected target
    assign ram_bus.req     = issue && (sel == SEL_RAM);
    assign ram_bus.we      = we_i;
    assign ram_bus.addr    = addr_i;
    assign ram_bus.wdata   = wdata_i;
    assign ram_bus.wem     = wem_i;

    assign timer_bus.req   = issue && (sel == SEL_TIMER);
    assign timer_bus.we    = we_i;
    assign timer_bus.addr  = addr_i;
    assign timer_bus.wdata = wdata_i;
    assign timer_bus.wem   = wem_i;

    assign gpio_bus.req    = issue && (sel == SEL_GPIO);
    assign gpio_bus.we     = we_i;
    assign gpio_bus.addr   = addr_i;
    assign gpio_bus.wdata  = wdata_i;
    assign gpio_bus.wem    = wem_i;

    // unmapped requests are accepted here
    always_comb begin
        case (sel)
            SEL_RAM:   addr_ok_o = ram_bus.addr_ok;
            SEL_TIMER: addr_ok_o = timer_bus.addr_ok;
            SEL_GPIO:  addr_ok_o = gpio_bus.addr_ok;
            default:   addr_ok_o = issue;
        endcase
    end

    // response from the target of the accepted request
    always_comb begin
        case (sel_q)
            SEL_RAM: begin
                data_ok_o = ram_bus.data_ok;
                rdata_o   = ram_bus.rdata;
            end
            SEL_TIMER: begin
                data_ok_o = timer_bus.data_ok;
                rdata_o   = timer_bus.rdata;
            end
            SEL_GPIO: begin
                data_ok_o = gpio_bus.data_ok;
                rdata_o   = gpio_bus.rdata;
            end
            default: begin
                data_ok_o = decerr_q;
                rdata_o   = `SOC_DECERR_DATA;
            end
        endcase
    end

    assign err_o = decerr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            live_q   <= 1'b0;
            owed_q   <= 1'b0;
            decerr_q <= 1'b0;
            sel_q    <= SEL_NONE;
        end else begin
            // bus opens one cycle after reset release
            live_q   <= 1'b1;
            decerr_q <= addr_ok_o && (sel == SEL_NONE);
            if (addr_ok_o) begin
                owed_q <= 1'b1;
                sel_q  <= sel;
            end else if (data_ok_o) begin
                owed_q <= 1'b0;
            end
        end
    end

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module data_ram (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);
    import soc_pkg::*;

    localparam int IDX_W = $clog2(`SOC_RAM_WORDS);

    word_t            mem [`SOC_RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             acc;
    logic             data_ok_q;
    word_t            rdata_q;

    // word index above the byte offset, wraps within depth
    assign idx = bus.addr[IDX_W+1:2];

    // accept unless the previous response is still going out
    assign bus.addr_ok = bus.req && !data_ok_q;
    assign acc         = bus.addr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= acc;
        end
    end

    // storage and read data
    always_ff @(posedge clk) begin
        if (acc && bus.we) begin
            for (int b = 0; b < `SOC_STRB_W; b++) begin
                if (bus.wem[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
        if (acc && !bus.we) begin
            rdata_q <= mem[idx];
        end
    end

    assign bus.data_ok = data_ok_q;
    assign bus.rdata   = rdata_q;

endmodule

/* verilog/timer.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module timer (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus,
    output logic     int_o
);
    import soc_pkg::*;

    timer_reg_e reg_sel;
    logic       acc;
    logic       ctrl_wr;
    logic       hit;
    logic       en_q;
    logic       ie_q;
    logic       pend_q;
    word_t      count_q;
    word_t      value_q;
    logic       data_ok_q;
    word_t      rdata_q;

    assign bus.addr_ok = bus.req && !data_ok_q;
    assign acc         = bus.addr_ok;
    assign reg_sel     = timer_reg_e'(bus.addr[3:0]);
    assign ctrl_wr     = acc && bus.we && (reg_sel == TMR_CTRL);

    //////////////////////////////////////////////////////////////////////
    // register section
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q    <= 1'b0;
            ie_q    <= 1'b0;
            value_q <= '0;
        end else if (acc && bus.we) begin
            case (reg_sel)
                TMR_CTRL: begin
                    en_q <= bus.wdata[0];
                    ie_q <= bus.wdata[1];
                end
                TMR_VALUE: value_q <= bus.wdata;
                // count is read-only
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // counter and compare
    //////////////////////////////////////////////////////////////////////

    assign hit = en_q && (count_q == value_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            pend_q  <= 1'b0;
        end else begin
            // a new match beats a same-cycle clear
            pend_q <= hit || (pend_q && !(ctrl_wr && bus.wdata[2]));
            if (ctrl_wr && !bus.wdata[0]) begin
                count_q <= '0;
            end else if (hit) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign int_o = pend_q && ie_q;

    //////////////////////////////////////////////////////////////////////
    // bus response
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= acc;
        end
    end

    always_ff @(posedge clk) begin
        if (acc && !bus.we) begin
            case (reg_sel)
                TMR_CTRL:  rdata_q <= word_t'({pend_q, ie_q, en_q});
                TMR_COUNT: rdata_q <= count_q;
                TMR_VALUE: rdata_q <= value_q;
                default:   rdata_q <= '0;
            endcase
        end
    end

    assign bus.data_ok = data_ok_q;
    assign bus.rdata   = rdata_q;

endmodule

/* verilog/gpio.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module gpio (
    input  logic                      clk,
    input  logic                      rst_n,
    mem_bus_if.slave                  bus,
    input  logic [`SOC_GPIO_PINS-1:0] pin_i,
    output logic [`SOC_GPIO_PINS-1:0] pin_o,
    output logic [`SOC_GPIO_PINS-1:0] pin_oe_o
);
    import soc_pkg::*;

    localparam int PINS = `SOC_GPIO_PINS;

    gpio_reg_e         reg_sel;
    logic              acc;
    logic [2*PINS-1:0] ctrl_q;
    logic [PINS-1:0]   data_q;
    logic [PINS-1:0]   pin_meta_q;
    logic [PINS-1:0]   pin_sync_q;
    logic [PINS-1:0]   pin_rd;
    logic              data_ok_q;
    word_t             rdata_q;

    assign bus.addr_ok = bus.req && !data_ok_q;
    assign acc         = bus.addr_ok;
    assign reg_sel     = gpio_reg_e'(bus.addr[3:0]);

    // control and output data registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
            data_q <= '0;
        end else if (acc && bus.we) begin
            case (reg_sel)
                GPIO_CTRL: ctrl_q <= bus.wdata[2*PINS-1:0];
                GPIO_DATA: data_q <= bus.wdata[PINS-1:0];
                default: ;
            endcase
        end
    end

    // two bits per pin, code 01 drives the pad
    always_comb begin
        for (int i = 0; i < PINS; i++) begin
            pin_oe_o[i] = (ctrl_q[2*i +: 2] == 2'b01);
        end
    end

    assign pin_o = data_q;

    // pad inputs are asynchronous
    always_ff @(posedge clk) begin
        pin_meta_q <= pin_i;
        pin_sync_q <= pin_meta_q;
    end

    // output pins read back their own value
    assign pin_rd = (data_q & pin_oe_o) | (pin_sync_q & ~pin_oe_o);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_ok_q <= 1'b0;
        end else begin
            data_ok_q <= acc;
        end
    end

    always_ff @(posedge clk) begin
        if (acc && !bus.we) begin
            case (reg_sel)
                GPIO_CTRL: rdata_q <= word_t'(ctrl_q);
                GPIO_DATA: rdata_q <= word_t'(pin_rd);
                default:   rdata_q <= '0;
            endcase
        end
    end

    assign bus.data_ok = data_ok_q;
    assign bus.rdata   = rdata_q;

endmodule

/* verilog/soc_top.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
    input  logic                      clk,
    input  logic                      rst_ext_i,
    // external bus master
    input  logic                      bus_req_i,
    input  logic                      bus_we_i,
    input  soc_pkg::addr_t            bus_addr_i,
    input  soc_pkg::word_t            bus_wdata_i,
    input  soc_pkg::strb_t            bus_wem_i,
    output logic                      bus_addr_ok_o,
    output logic                      bus_data_ok_o,
    output logic                      bus_err_o,
    output soc_pkg::word_t            bus_rdata_o,
    // peripherals
    output logic                      timer_int_o,
    input  logic [`SOC_GPIO_PINS-1:0] gpio_i,
    output logic [`SOC_GPIO_PINS-1:0] gpio_o,
    output logic [`SOC_GPIO_PINS-1:0] gpio_oe_o
);

    logic [1:0] rst_sync_q;
    logic       rst_n;

    //////////////////////////////////////////////////////////////////////
    // reset synchronizer
    //////////////////////////////////////////////////////////////////////

    // async assert, release after two clk edges
    always_ff @(posedge clk or negedge rst_ext_i) begin
        if (!rst_ext_i) begin
            rst_sync_q <= 2'b00;
        end else begin
            rst_sync_q <= {rst_sync_q[0], 1'b1};
        end
    end

    assign rst_n = rst_sync_q[1];

    //////////////////////////////////////////////////////////////////////
    // fabric and peripherals
    //////////////////////////////////////////////////////////////////////

    mem_bus_if ram_bus ();
    mem_bus_if timer_bus ();
    mem_bus_if gpio_bus ();

    bus_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (bus_req_i),
        .we_i      (bus_we_i),
        .addr_i    (bus_addr_i),
        .wdata_i   (bus_wdata_i),
        .wem_i     (bus_wem_i),
        .addr_ok_o (bus_addr_ok_o),
        .data_ok_o (bus_data_ok_o),
        .rdata_o   (bus_rdata_o),
        .err_o     (bus_err_o),
        .ram_bus   (ram_bus.master),
        .timer_bus (timer_bus.master),
        .gpio_bus  (gpio_bus.master)
    );

    data_ram u_ram (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.slave)
    );

    timer u_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (timer_bus.slave),
        .int_o (timer_int_o)
    );

    gpio u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (gpio_bus.slave),
        .pin_i    (gpio_i),
        .pin_o    (gpio_o),
        .pin_oe_o (gpio_oe_o)
    );

endmodule

/* verif/soc_props.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_props (
    input logic           clk,
    input logic           rst_n,
    input logic           req_i,
    input logic           we_i,
    input soc_pkg::addr_t addr_i,
    input soc_pkg::word_t wdata_i,
    input logic           addr_ok_i,
    input logic           data_ok_i,
    input logic           int_i
);
    import soc_pkg::*;

    logic ctrl_wr;
    logic ie_q;

    // accepted write to the timer control register
    assign ctrl_wr = req_i && addr_ok_i && we_i &&
                     (addr_i[`SOC_SEL_MSB -: 4] == `SOC_REGION_TIMER) &&
                     (addr_i[3:0] == TMR_CTRL);

    // interrupt enable as last written over the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ie_q <= 1'b0;
        end else if (ctrl_wr) begin
            ie_q <= wdata_i[1];
        end
    end

    // one response per accept, exactly one cycle later
    a_data_ok_follows_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_ok_i == $past(addr_ok_i)
    ) else $error("bus_data_ok_o does not follow an accepted request by one cycle");

    a_addr_ok_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        addr_ok_i |-> req_i
    ) else $error("bus_addr_ok_o high without bus_req_i");

    // masked interrupt never reaches the pin
    a_int_masked: assert property (
        @(posedge clk) disable iff (!rst_n)
        !ie_q |-> !int_i
    ) else $error("timer_int_o high while the timer interrupt enable is clear");

endmodule

bind soc_top soc_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_i     (bus_req_i),
    .we_i      (bus_we_i),
    .addr_i    (bus_addr_i),
    .wdata_i   (bus_wdata_i),
    .addr_ok_i (bus_addr_ok_o),
    .data_ok_i (bus_data_ok_o),
    .int_i     (timer_int_o)
);

/* verif/soc_tb.sv */
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_tb;
    import soc_pkg::*;

    localparam int PINS        = `SOC_GPIO_PINS;
    localparam int IDX_W       = $clog2(`SOC_RAM_WORDS);
    localparam int RAM_XFERS   = 300;
    localparam int DEC_XFERS   = 20;
    localparam int GPIO_ROUNDS = 8;
    localparam int TMR_ROUNDS  = 3;
    // each decode error may be followed by a RAM read back
    localparam int N_XFERS     = RAM_XFERS + 2 * DEC_XFERS + 4 * GPIO_ROUNDS + 37 * TMR_ROUNDS;
    localparam int LIMIT       = 20 * N_XFERS + 2000;

    localparam addr_t TMR_BASE  = {`SOC_REGION_TIMER, 28'h0};
    localparam addr_t GPIO_BASE = {`SOC_REGION_GPIO, 28'h0};

    logic            clk;
    logic            rst_ext_i;
    logic            bus_req_i;
    logic            bus_we_i;
    addr_t           bus_addr_i;
    word_t           bus_wdata_i;
    strb_t           bus_wem_i;
    logic            bus_addr_ok_o;
    logic            bus_data_ok_o;
    logic            bus_err_o;
    word_t           bus_rdata_o;
    logic            timer_int_o;
    logic [PINS-1:0] gpio_i;
    logic [PINS-1:0] gpio_o;
    logic [PINS-1:0] gpio_oe_o;

    // reference model of the RAM, keyed by word index
    word_t ram_model [int];
    int    errors;
    int    tests_run;
    int    tests_failed;
    int    n_xfers;
    int    cycles = 0;

    soc_top dut (.*);

    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // run limit
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%-14s passed", name);
        end else begin
            tests_failed++;
            $display("%-14s failed (%0d errors)", name, errors - err_before);
        end
    endtask

    function automatic word_t merge_bytes(input word_t old, input word_t wd, input strb_t wem);
        word_t res;
        res = old;
        for (int b = 0; b < `SOC_STRB_W; b++) begin
            if (wem[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    // one transaction, checks accept and response timing
    task automatic bus_xfer(input logic we, input addr_t addr, input word_t wdata,
                            input strb_t wem, input logic exp_err, output word_t rdata);
        int wait_acc;
        int wait_rsp;
        wait_acc = 0;
        wait_rsp = 1;
        @(posedge clk);
        bus_req_i   <= 1'b1;
        bus_we_i    <= we;
        bus_addr_i  <= addr;
        bus_wdata_i <= wdata;
        bus_wem_i   <= wem;
        @(negedge clk);
        while (!bus_addr_ok_o) begin
            @(negedge clk);
            wait_acc++;
        end
        check("addr_ok in the request cycle", 32'(wait_acc), 32'd0);
        check("data_ok low in the accept cycle", 32'(bus_data_ok_o), 32'd0);
        @(posedge clk);
        bus_req_i <= 1'b0;
        @(negedge clk);
        while (!bus_data_ok_o) begin
            @(negedge clk);
            wait_rsp++;
        end
        check("data_ok one cycle after accept", 32'(wait_rsp), 32'd1);
        check("bus_err_o", 32'(bus_err_o), 32'(exp_err));
        rdata = bus_rdata_o;
        n_xfers++;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    task automatic ram_random();
        int    e0;
        int    idx;
        logic  we;
        strb_t wem;
        word_t wd;
        word_t rd;
        addr_t a;
        e0 = errors;
        for (int n = 0; n < RAM_XFERS; n++) begin
            idx = int'($urandom % `SOC_RAM_WORDS);
            we  = 1'($urandom);
            wem = strb_t'($urandom);
            wd  = $urandom;
            // first access to a word writes all of it
            if (!ram_model.exists(idx)) begin
                we  = 1'b1;
                wem = '1;
            end
            // upper offset bits are random to exercise the wrap
            a             = $urandom;
            a[31:28]      = `SOC_REGION_RAM;
            a[IDX_W+1:2]  = IDX_W'(idx);
            a[1:0]        = 2'b00;
            bus_xfer(we, a, wd, wem, 1'b0, rd);
            if (we) begin
                ram_model[idx] = merge_bytes(ram_model.exists(idx) ? ram_model[idx] : '0, wd, wem);
            end else begin
                check("ram read data", rd, ram_model[idx]);
            end
        end
        report_test("ram_random", e0);
    endtask

    task automatic decode_error();
        int         e0;
        int         idx;
        logic [3:0] region;
        addr_t      a;
        word_t      rd;
        e0 = errors;
        for (int n = 0; n < DEC_XFERS; n++) begin
            region = 4'($urandom);
            while (region == `SOC_REGION_RAM || region == `SOC_REGION_TIMER ||
                   region == `SOC_REGION_GPIO) begin
                region = 4'($urandom);
            end
            a        = $urandom;
            a[31:28] = region;
            a[1:0]   = 2'b00;
            bus_xfer(1'($urandom), a, $urandom, strb_t'($urandom), 1'b1, rd);
            check("decode error data", rd, `SOC_DECERR_DATA);
            // the RAM word under the same offset must be untouched
            idx = int'(a[IDX_W+1:2]);
            if (ram_model.exists(idx)) begin
                a[31:28] = `SOC_REGION_RAM;
                bus_xfer(1'b0, a, '0, '1, 1'b0, rd);
                check("ram after decode error", rd, ram_model[idx]);
            end
        end
        report_test("decode_error", e0);
    endtask

    task automatic gpio_test();
        int                e0;
        logic [2*PINS-1:0] ctrl_m;
        logic [PINS-1:0]   data_m;
        logic [PINS-1:0]   pins;
        logic [PINS-1:0]   exp_oe;
        word_t             rd;
        e0 = errors;
        for (int r = 0; r < GPIO_ROUNDS; r++) begin
            ctrl_m = (2*PINS)'($urandom);
            data_m = PINS'($urandom);
            pins   = PINS'($urandom);
            @(posedge clk);
            gpio_i <= pins;
            bus_xfer(1'b1, GPIO_BASE | addr_t'(GPIO_CTRL), word_t'(ctrl_m), '1, 1'b0, rd);
            bus_xfer(1'b1, GPIO_BASE | addr_t'(GPIO_DATA), word_t'(data_m), '1, 1'b0, rd);
            for (int i = 0; i < PINS; i++) begin
                exp_oe[i] = (ctrl_m[2*i +: 2] == 2'b01);
            end
            check("gpio_oe_o", 32'(gpio_oe_o), 32'(exp_oe));
            check("gpio_o", 32'(gpio_o), 32'(data_m));
            bus_xfer(1'b0, GPIO_BASE | addr_t'(GPIO_DATA), '0, '1, 1'b0, rd);
            check("gpio data read", rd, word_t'((data_m & exp_oe) | (pins & ~exp_oe)));
            bus_xfer(1'b0, GPIO_BASE | addr_t'(GPIO_CTRL), '0, '1, 1'b0, rd);
            check("gpio ctrl read", rd, word_t'(ctrl_m));
        end
        report_test("gpio", e0);
    endtask

    task automatic timer_test();
        int    e0;
        int    v;
        int    waited;
        logic  seen;
        word_t rd;
        e0 = errors;
        for (int r = 0; r < TMR_ROUNDS; r++) begin
            v = 5 + int'($urandom % 36);
            bus_xfer(1'b1, TMR_BASE | addr_t'(TMR_VALUE), word_t'(v), '1, 1'b0, rd);
            bus_xfer(1'b1, TMR_BASE | addr_t'(TMR_CTRL), 32'h3, '1, 1'b0, rd);
            waited = 0;
            while (!timer_int_o && waited <= v + 3) begin
                @(negedge clk);
                waited++;
            end
            check("timer_int_o within value+3 cycles", 32'(timer_int_o), 32'd1);
            bus_xfer(1'b0, TMR_BASE | addr_t'(TMR_COUNT), '0, '1, 1'b0, rd);
            check("count not above value", 32'(rd <= word_t'(v)), 32'd1);
            // stop first so that no new match meets the clear
            bus_xfer(1'b1, TMR_BASE | addr_t'(TMR_CTRL), 32'h2, '1, 1'b0, rd);
            bus_xfer(1'b1, TMR_BASE | addr_t'(TMR_CTRL), 32'h6, '1, 1'b0, rd);
            check("timer_int_o after pending clear", 32'(timer_int_o), 32'd0);
            // run again with the interrupt masked
            bus_xfer(1'b1, TMR_BASE | addr_t'(TMR_CTRL), 32'h1, '1, 1'b0, rd);
            seen = 1'b0;
            for (int k = 0; k < 30 && !seen; k++) begin
                bus_xfer(1'b0, TMR_BASE | addr_t'(TMR_CTRL), '0, '1, 1'b0, rd);
                check("timer_int_o while masked", 32'(timer_int_o), 32'd0);
                seen = rd[2];
            end
            check("pending set while masked", 32'(seen), 32'd1);
            bus_xfer(1'b1, TMR_BASE | addr_t'(TMR_CTRL), 32'h4, '1, 1'b0, rd);
        end
        report_test("timer", e0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int e0;
        clk          = 1'b0;
        rst_ext_i    = 1'b0;
        bus_req_i    = 1'b0;
        bus_we_i     = 1'b0;
        bus_addr_i   = '0;
        bus_wdata_i  = '0;
        bus_wem_i    = '0;
        gpio_i       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        n_xfers      = 0;
        void'($urandom(95));

        e0 = errors;
        repeat (16) begin
            @(negedge clk);
            check("outputs in reset",
                  32'({bus_addr_ok_o, bus_data_ok_o, bus_err_o, timer_int_o, gpio_oe_o}), 32'd0);
        end
        @(posedge clk);
        rst_ext_i <= 1'b1;
        repeat (6) begin
            @(negedge clk);
            check("bus idle after reset", 32'({bus_addr_ok_o, bus_data_ok_o}), 32'd0);
        end
        report_test("reset_idle", e0);

        ram_random();
        decode_error();
        gpio_test();
        timer_test();

        $display("summary: %0d tests, %0d failed, %0d transactions, %0d check errors",
                 tests_run, tests_failed, n_xfers, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+verilog
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/bus_decoder.sv
verilog/data_ram.sv
verilog/timer.sv
verilog/gpio.sv
verilog/soc_top.sv
verif/soc_props.sv
verif/soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= soc_tb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

# build, run, and pass only if the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJDIR)
